//--- dispatch_pkg.sv
package dispatch_pkg;

    // datapath and register file sizes
    localparam int WORD_W  = 32;
    localparam int S_REGS  = 32;
    localparam int M_REGS  = 16;
    localparam int S_SEL_W = 5;
    localparam int M_SEL_W = 4;
    localparam int NUM_FU  = 5;

    // producer tag kept per register in the status tables
    typedef logic [1:0] tag_t;

    localparam tag_t TAG_NONE  = 2'd0;
    localparam tag_t TAG_ARITH = 2'd1;
    localparam tag_t TAG_LOAD  = 2'd2;

    // functional unit ids, also the bit index into the busy vector
    typedef logic [2:0] fu_id_t;

    localparam fu_id_t FU_ALU  = 3'd0;
    localparam fu_id_t FU_SLS  = 3'd1;
    localparam fu_id_t FU_BR   = 3'd2;
    localparam fu_id_t FU_MLS  = 3'd3;
    localparam fu_id_t FU_GEMM = 3'd4;
    localparam fu_id_t FU_NONE = 3'd7;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_MLOAD  = 7'b0000111;
    localparam logic [6:0] OPC_MSTORE = 7'b0100111;
    localparam logic [6:0] OPC_GEMM   = 7'b1110111;

    // {funct7[5], funct3}
    typedef logic [3:0] alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } scalar_fmt_t;

    // matrix ops put the four register fields at the top of the word
    typedef struct packed {
        logic [3:0] md;
        logic [3:0] ms1;
        logic [3:0] ms2;
        logic [3:0] ms3;
        logic [8:0] rsvd;
        logic [6:0] opcode;
    } matrix_fmt_t;

    // one fetched word, viewed in either layout
    typedef union packed {
        scalar_fmt_t scalar;
        matrix_fmt_t matrix;
    } instr_u;

endpackage

//--- control_unit.sv
`timescale 1ns/10ps

module control_unit import dispatch_pkg::*; (
    input  instr_u            instr,
    output fu_id_t            fu,
    output logic              s_reg_write,
    output logic              m_reg_write,
    output logic              uses_matrix_src,
    output alu_op_t           alu_op,
    output logic [WORD_W-1:0] imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr.scalar.opcode;
    assign funct3 = instr.scalar.funct3;
    assign funct7 = instr.scalar.funct7;

    always_comb begin
        fu              = FU_NONE;
        s_reg_write     = 1'b0;
        m_reg_write     = 1'b0;
        uses_matrix_src = 1'b0;
        // address adds by default
        alu_op          = 4'b0000;
        imm             = '0;

        case (opcode)
            OPC_OP: begin
                fu          = FU_ALU;
                s_reg_write = 1'b1;
                alu_op      = {funct7[5], funct3};
            end
            OPC_OPIMM: begin
                fu          = FU_ALU;
                s_reg_write = 1'b1;
                // only srai keeps the funct7 bit, elsewhere it is immediate
                alu_op      = {(funct3 == 3'b101) & funct7[5], funct3};
                imm         = {{20{instr[31]}}, instr[31:20]};
            end
            OPC_LOAD: begin
                fu          = FU_SLS;
                s_reg_write = 1'b1;
                imm         = {{20{instr[31]}}, instr[31:20]};
            end
            OPC_STORE: begin
                fu  = FU_SLS;
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OPC_BRANCH: begin
                fu     = FU_BR;
                alu_op = {1'b0, funct3};
                imm    = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                          instr[11:8], 1'b0};
            end
            OPC_MLOAD: begin
                // matrix destination, scalar base register in rs1
                fu          = FU_MLS;
                m_reg_write = 1'b1;
                imm         = {{24{instr.matrix.ms1[3]}}, instr.matrix.ms1,
                               instr.matrix.ms2};
            end
            OPC_MSTORE: begin
                fu  = FU_MLS;
                imm = {{24{instr.matrix.ms1[3]}}, instr.matrix.ms1, instr.matrix.ms2};
            end
            OPC_GEMM: begin
                // md = ms1 * ms2 + ms3
                fu              = FU_GEMM;
                m_reg_write     = 1'b1;
                uses_matrix_src = 1'b1;
            end
            default: begin
                fu = FU_NONE;
            end
        endcase
    end

endmodule

//--- reg_status_table.sv
`timescale 1ns/10ps

module reg_status_table import dispatch_pkg::*; #(
    parameter int NREGS = S_REGS
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     di_write,
    input  logic [$clog2(NREGS)-1:0] di_sel,
    input  tag_t                     di_tag,
    input  logic                     di_spec,
    input  logic                     wb_write,
    input  logic [$clog2(NREGS)-1:0] wb_sel,
    input  logic                     flush,
    input  logic [$clog2(NREGS)-1:0] rd_sel1,
    input  logic [$clog2(NREGS)-1:0] rd_sel2,
    input  logic [$clog2(NREGS)-1:0] rd_sel3,
    input  logic [$clog2(NREGS)-1:0] rd_sel4,
    output tag_t                     tag1,
    output tag_t                     tag2,
    output tag_t                     tag3,
    output logic                     pend4
);

    tag_t tags [NREGS];
    logic spec [NREGS];

    // later assignments override earlier ones, so dispatch beats writeback
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NREGS; i++) begin
                tags[i] <= TAG_NONE;
                spec[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < NREGS; i++) begin
                if (flush && spec[i]) begin
                    tags[i] <= TAG_NONE;
                    spec[i] <= 1'b0;
                end
            end
            if (wb_write) begin
                tags[wb_sel] <= TAG_NONE;
                spec[wb_sel] <= 1'b0;
            end
            if (di_write) begin
                tags[di_sel] <= di_tag;
                spec[di_sel] <= di_spec;
            end
        end
    end

    // source producers
    assign tag1 = tags[rd_sel1];
    assign tag2 = tags[rd_sel2];
    assign tag3 = tags[rd_sel3];

    // destination still owned by an earlier instruction
    assign pend4 = (tags[rd_sel4] != TAG_NONE);

endmodule

//--- fu_status.sv
`timescale 1ns/10ps

module fu_status import dispatch_pkg::*; (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              disp_fire,
    input  fu_id_t            disp_fu,
    input  logic              fu_done_valid,
    input  fu_id_t            fu_done_id,
    output logic [NUM_FU-1:0] fu_busy
);

    logic [NUM_FU-1:0] set_mask;
    logic [NUM_FU-1:0] clr_mask;

    // one-hot set and clear, ids outside the unit range are ignored
    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        if (disp_fire && disp_fu < NUM_FU) begin
            set_mask[disp_fu] = 1'b1;
        end
        if (fu_done_valid && fu_done_id < NUM_FU) begin
            clr_mask[fu_done_id] = 1'b1;
        end
    end

    // a new dispatch to a unit overrides its completion in the same cycle
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fu_busy <= '0;
        end else begin
            fu_busy <= (fu_busy & ~clr_mask) | set_mask;
        end
    end

endmodule

//--- dispatch.sv
`timescale 1ns/10ps

module dispatch import dispatch_pkg::*; (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               instr_valid,
    input  instr_u             instr,
    output logic               instr_ready,
    input  logic               branch_resolved,
    input  logic               branch_miss,
    input  logic               s_wb_en,
    input  logic [S_SEL_W-1:0] s_wb_reg,
    input  logic               m_wb_en,
    input  logic [M_SEL_W-1:0] m_wb_reg,
    input  logic [NUM_FU-1:0]  fu_busy,
    output logic               disp_fire,
    output fu_id_t             disp_fu,
    output logic               issue_valid,
    output fu_id_t             issue_fu,
    output alu_op_t            issue_alu_op,
    output logic [S_SEL_W-1:0] issue_rd,
    output logic [S_SEL_W-1:0] issue_rs1,
    output logic [S_SEL_W-1:0] issue_rs2,
    output logic [S_SEL_W-1:0] issue_rs3,
    output logic [WORD_W-1:0]  issue_imm,
    output tag_t               issue_t1,
    output tag_t               issue_t2,
    output tag_t               issue_t3,
    output logic               issue_spec
);

    fu_id_t             cu_fu;
    logic               s_reg_write;
    logic               m_reg_write;
    logic               uses_matrix_src;
    alu_op_t            cu_alu_op;
    logic [WORD_W-1:0]  cu_imm;

    logic [S_SEL_W-1:0] s_rd, s_rs1, s_rs2;
    logic [M_SEL_W-1:0] m_rd, m_rs1, m_rs2, m_rs3;
    tag_t               s_tag1, s_tag2;
    tag_t               m_tag1, m_tag2, m_tag3;
    logic               s_pend, m_pend;

    logic               unit_busy;
    logic               hazard;
    logic               fire;
    logic               m_dest;
    logic               spec;
    tag_t               new_tag;

    control_unit u_cu (
        .instr           (instr),
        .fu              (cu_fu),
        .s_reg_write     (s_reg_write),
        .m_reg_write     (m_reg_write),
        .uses_matrix_src (uses_matrix_src),
        .alu_op          (cu_alu_op),
        .imm             (cu_imm)
    );

    assign s_rd  = instr.scalar.rd;
    assign s_rs1 = instr.scalar.rs1;
    assign s_rs2 = instr.scalar.rs2;
    assign m_rd  = instr.matrix.md;
    assign m_rs1 = instr.matrix.ms1;
    assign m_rs2 = instr.matrix.ms2;
    assign m_rs3 = instr.matrix.ms3;

    // structural hazard on the decoded unit
    always_comb begin
        if (cu_fu < NUM_FU) begin
            unit_busy = fu_busy[cu_fu];
        end else begin
            unit_busy = 1'b0;
        end
    end

    // waw only matters for instructions that write a register
    assign hazard = unit_busy | (s_reg_write & s_pend) | (m_reg_write & m_pend);

    // during a miss the word is consumed and dropped
    assign instr_ready = ~hazard | branch_miss;
    assign fire        = instr_valid & ~hazard & ~branch_miss & (cu_fu != FU_NONE);
    assign disp_fire   = fire;
    assign disp_fu     = cu_fu;

    assign new_tag = (cu_fu == FU_SLS || cu_fu == FU_MLS) ? TAG_LOAD : TAG_ARITH;
    assign m_dest  = (cu_fu == FU_MLS) || (cu_fu == FU_GEMM);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            spec <= 1'b0;
        end else if (fire && cu_fu == FU_BR) begin
            spec <= 1'b1;
        end else if (branch_resolved || branch_miss) begin
            spec <= 1'b0;
        end
    end

    // scalar formats carry only two sources
    reg_status_table #(.NREGS(S_REGS)) u_rst_s (
        .CLK      (CLK),
        .nRST     (nRST),
        .di_write (fire & s_reg_write),
        .di_sel   (s_rd),
        .di_tag   (new_tag),
        .di_spec  (spec),
        .wb_write (s_wb_en),
        .wb_sel   (s_wb_reg),
        .flush    (branch_miss),
        .rd_sel1  (s_rs1),
        .rd_sel2  (s_rs2),
        .rd_sel3  (s_rd),
        .rd_sel4  (s_rd),
        .tag1     (s_tag1),
        .tag2     (s_tag2),
        .tag3     (),
        .pend4    (s_pend)
    );

    reg_status_table #(.NREGS(M_REGS)) u_rst_m (
        .CLK      (CLK),
        .nRST     (nRST),
        .di_write (fire & m_reg_write),
        .di_sel   (m_rd),
        .di_tag   (new_tag),
        .di_spec  (spec),
        .wb_write (m_wb_en),
        .wb_sel   (m_wb_reg),
        .flush    (branch_miss),
        .rd_sel1  (m_rs1),
        .rd_sel2  (m_rs2),
        .rd_sel3  (m_rs3),
        .rd_sel4  (m_rd),
        .tag1     (m_tag1),
        .tag2     (m_tag2),
        .tag3     (m_tag3),
        .pend4    (m_pend)
    );

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= fire;
        end
    end

    // issue payload, only meaningful while issue_valid is high
    always_ff @(posedge CLK) begin
        if (fire) begin
            issue_fu     <= cu_fu;
            issue_alu_op <= cu_alu_op;
            issue_imm    <= cu_imm;
            issue_spec   <= spec;
            issue_rd     <= m_dest ? S_SEL_W'(m_rd) : s_rd;
            issue_rs1    <= uses_matrix_src ? S_SEL_W'(m_rs1) : s_rs1;
            issue_rs2    <= uses_matrix_src ? S_SEL_W'(m_rs2) : s_rs2;
            issue_rs3    <= uses_matrix_src ? S_SEL_W'(m_rs3) : '0;
            issue_t1     <= uses_matrix_src ? m_tag1 : s_tag1;
            issue_t2     <= uses_matrix_src ? m_tag2 : s_tag2;
            issue_t3     <= uses_matrix_src ? m_tag3 : TAG_NONE;
        end
    end

endmodule

//--- dispatch_top.sv
`timescale 1ns/10ps

module dispatch_top import dispatch_pkg::*; (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               instr_valid,
    input  instr_u             instr,
    output logic               instr_ready,
    input  logic               fu_done_valid,
    input  fu_id_t             fu_done_id,
    input  logic               s_wb_en,
    input  logic [S_SEL_W-1:0] s_wb_reg,
    input  logic               m_wb_en,
    input  logic [M_SEL_W-1:0] m_wb_reg,
    input  logic               branch_resolved,
    input  logic               branch_miss,
    output logic               issue_valid,
    output fu_id_t             issue_fu,
    output alu_op_t            issue_alu_op,
    output logic [S_SEL_W-1:0] issue_rd,
    output logic [S_SEL_W-1:0] issue_rs1,
    output logic [S_SEL_W-1:0] issue_rs2,
    output logic [S_SEL_W-1:0] issue_rs3,
    output logic [WORD_W-1:0]  issue_imm,
    output tag_t               issue_t1,
    output tag_t               issue_t2,
    output tag_t               issue_t3,
    output logic               issue_spec
);

    logic [NUM_FU-1:0] fu_busy;
    logic              disp_fire;
    fu_id_t            disp_fu;

    dispatch u_dispatch (
        .CLK             (CLK),
        .nRST            (nRST),
        .instr_valid     (instr_valid),
        .instr           (instr),
        .instr_ready     (instr_ready),
        .branch_resolved (branch_resolved),
        .branch_miss     (branch_miss),
        .s_wb_en         (s_wb_en),
        .s_wb_reg        (s_wb_reg),
        .m_wb_en         (m_wb_en),
        .m_wb_reg        (m_wb_reg),
        .fu_busy         (fu_busy),
        .disp_fire       (disp_fire),
        .disp_fu         (disp_fu),
        .issue_valid     (issue_valid),
        .issue_fu        (issue_fu),
        .issue_alu_op    (issue_alu_op),
        .issue_rd        (issue_rd),
        .issue_rs1       (issue_rs1),
        .issue_rs2       (issue_rs2),
        .issue_rs3       (issue_rs3),
        .issue_imm       (issue_imm),
        .issue_t1        (issue_t1),
        .issue_t2        (issue_t2),
        .issue_t3        (issue_t3),
        .issue_spec      (issue_spec)
    );

    fu_status u_fu_status (
        .CLK           (CLK),
        .nRST          (nRST),
        .disp_fire     (disp_fire),
        .disp_fu       (disp_fu),
        .fu_done_valid (fu_done_valid),
        .fu_done_id    (fu_done_id),
        .fu_busy       (fu_busy)
    );

endmodule

//--- tb_dispatch.sv
`timescale 1ns/10ps

module tb_dispatch import dispatch_pkg::*; ();

    // about 300 cycles are needed for all tests
    localparam int MAX_CYCLES = 3000;

    logic               CLK;
    logic               nRST;
    logic               instr_valid;
    instr_u             instr;
    logic               instr_ready;
    logic               fu_done_valid;
    fu_id_t             fu_done_id;
    logic               s_wb_en;
    logic [S_SEL_W-1:0] s_wb_reg;
    logic               m_wb_en;
    logic [M_SEL_W-1:0] m_wb_reg;
    logic               branch_resolved;
    logic               branch_miss;
    logic               issue_valid;
    fu_id_t             issue_fu;
    alu_op_t            issue_alu_op;
    logic [S_SEL_W-1:0] issue_rd, issue_rs1, issue_rs2, issue_rs3;
    logic [WORD_W-1:0]  issue_imm;
    tag_t               issue_t1, issue_t2, issue_t3;
    logic               issue_spec;

    // reference model of the scoreboard
    tag_t              s_tags [S_REGS];
    logic              s_spec [S_REGS];
    tag_t              m_tags [M_REGS];
    logic              m_spec [M_REGS];
    logic [NUM_FU-1:0] busy;
    logic              spec_m;

    int     errors;
    int     checks;
    int     cycles;
    integer seed;
    string  test_name;

    dispatch_top uut (.*);

    always #50 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles in %s", cycles, test_name);
            $display("Errors found");
            $finish;
        end
    end

    // instruction encoders
    function automatic instr_u r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_u i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_u s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic instr_u b_word(input logic [12:0] off, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic instr_u m_word(input logic [3:0] md, input logic [3:0] ms1,
                                      input logic [3:0] ms2, input logic [3:0] ms3,
                                      input logic [6:0] opc);
        return {md, ms1, ms2, ms3, 9'd0, opc};
    endfunction

    task automatic check_field(input string field, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s %s: expected %h actual %h", test_name, field, exp, act);
        end
    endtask

    // offer one word and check its issue one cycle after acceptance
    task automatic send_and_check(input instr_u w, input fu_id_t e_fu, input alu_op_t e_alu,
                                  input logic [4:0] e_rd, input logic [4:0] e_rs1,
                                  input logic [4:0] e_rs2, input logic [4:0] e_rs3,
                                  input logic [31:0] e_imm, input logic sw,
                                  input logic mw, input logic msrc);
        tag_t e_t1;
        tag_t e_t2;
        tag_t e_t3;
        logic e_spec;
        tag_t new_tag;
        instr       = w;
        instr_valid = 1'b1;
        @(negedge CLK);
        while (!instr_ready) begin
            @(negedge CLK);
        end
        if (msrc) begin
            e_t1 = m_tags[e_rs1[3:0]];
            e_t2 = m_tags[e_rs2[3:0]];
            e_t3 = m_tags[e_rs3[3:0]];
        end else begin
            e_t1 = s_tags[e_rs1];
            e_t2 = s_tags[e_rs2];
            e_t3 = TAG_NONE;
        end
        e_spec = spec_m;
        @(posedge CLK);
        #10;
        instr_valid = 1'b0;
        check_field("issue_valid", 1, issue_valid);
        check_field("fu", e_fu, issue_fu);
        check_field("alu_op", e_alu, issue_alu_op);
        check_field("rd", e_rd, issue_rd);
        check_field("rs1", e_rs1, issue_rs1);
        check_field("rs2", e_rs2, issue_rs2);
        check_field("rs3", e_rs3, issue_rs3);
        check_field("imm", e_imm, issue_imm);
        check_field("t1", e_t1, issue_t1);
        check_field("t2", e_t2, issue_t2);
        check_field("t3", e_t3, issue_t3);
        check_field("spec", e_spec, issue_spec);
        // loads leave a load tag and everything else an arithmetic one
        new_tag = (e_fu == FU_SLS || e_fu == FU_MLS) ? TAG_LOAD : TAG_ARITH;
        busy[e_fu] = 1'b1;
        if (sw) begin
            s_tags[e_rd] = new_tag;
            s_spec[e_rd] = e_spec;
        end
        if (mw) begin
            m_tags[e_rd[3:0]] = new_tag;
            m_spec[e_rd[3:0]] = e_spec;
        end
        if (e_fu == FU_BR) begin
            spec_m = 1'b1;
        end
    endtask

    // one cycle of unit completion and register writeback
    task automatic retire(input logic done, input fu_id_t id, input logic sw,
                          input logic [4:0] sreg, input logic mw, input logic [3:0] mreg);
        fu_done_valid = done;
        fu_done_id    = id;
        s_wb_en       = sw;
        s_wb_reg      = sreg;
        m_wb_en       = mw;
        m_wb_reg      = mreg;
        @(posedge CLK);
        #10;
        fu_done_valid = 1'b0;
        s_wb_en       = 1'b0;
        m_wb_en       = 1'b0;
        if (done) begin
            busy[id] = 1'b0;
        end
        if (sw) begin
            s_tags[sreg] = TAG_NONE;
            s_spec[sreg] = 1'b0;
        end
        if (mw) begin
            m_tags[mreg] = TAG_NONE;
            m_spec[mreg] = 1'b0;
        end
    endtask

    task automatic hold_stall(input int n);
        repeat (n) begin
            @(negedge CLK);
            checks++;
            if (instr_ready !== 1'b0) begin
                errors++;
                $display("%s: instr_ready went high while the hazard was still there",
                         test_name);
            end
        end
        @(posedge CLK);
        #10;
    endtask

    task automatic reset_state();
        test_name = "reset_state";
        check_field("instr_ready", 1, instr_ready);
        check_field("issue_valid", 0, issue_valid);
        // sub x1, x2, x3
        send_and_check(r_word(7'b0100000, 5'd3, 5'd2, 3'b000, 5'd1), FU_ALU, 4'b1000,
                       1, 2, 3, 0, 0, 1, 0, 0);
        retire(1, FU_ALU, 1, 1, 0, 0);
        check_field("issue_valid one cycle later", 0, issue_valid);
    endtask

    task automatic raw_tags();
        test_name = "raw_tags";
        send_and_check(i_word(12'h010, 5'd6, 3'b010, 5'd5, OPC_LOAD), FU_SLS, 0,
                       5, 6, 16, 0, 32'h10, 1, 0, 0);
        send_and_check(r_word(7'd0, 5'd4, 5'd5, 3'b000, 5'd8), FU_ALU, 0, 8, 5, 4, 0, 0, 1, 0, 0);
        check_field("t1 behind load", TAG_LOAD, issue_t1);
        retire(1, FU_SLS, 1, 5, 0, 0);
        retire(1, FU_ALU, 1, 8, 0, 0);
        send_and_check(r_word(7'd0, 5'd8, 5'd5, 3'b111, 5'd9), FU_ALU, 4'b0111,
                       9, 5, 8, 0, 0, 1, 0, 0);
        check_field("t1 after writeback", TAG_NONE, issue_t1);
        retire(1, FU_ALU, 1, 9, 0, 0);
    endtask

    task automatic stall_release();
        test_name = "stall_busy_unit";
        send_and_check(r_word(7'd0, 5'd2, 5'd1, 3'b001, 5'd10), FU_ALU, 4'b0001,
                       10, 1, 2, 0, 0, 1, 0, 0);
        fork
            send_and_check(r_word(7'd0, 5'd10, 5'd3, 3'b100, 5'd11), FU_ALU, 4'b0100,
                           11, 3, 10, 0, 0, 1, 0, 0);
            begin
                hold_stall(3);
                retire(1, FU_ALU, 1, 10, 0, 0);
            end
        join
        retire(1, FU_ALU, 1, 11, 0, 0);
        test_name = "stall_pending_rd";
        send_and_check(i_word(12'hff8, 5'd2, 3'b010, 5'd12, OPC_LOAD), FU_SLS, 0,
                       12, 2, 5'h18, 0, 32'hfffffff8, 1, 0, 0);
        // unit free again but x12 still owed
        retire(1, FU_SLS, 0, 0, 0, 0);
        fork
            send_and_check(i_word(12'h004, 5'd3, 3'b010, 5'd12, OPC_LOAD), FU_SLS, 0,
                           12, 3, 4, 0, 32'h4, 1, 0, 0);
            begin
                hold_stall(3);
                retire(0, FU_NONE, 1, 12, 0, 0);
            end
        join
        retire(1, FU_SLS, 1, 12, 0, 0);
    endtask

    task automatic matrix_path();
        test_name = "matrix_path";
        // mload m3 with base x4 and offset 5
        send_and_check(m_word(4'd3, 4'd0, 4'd5, 4'd2, OPC_MLOAD), FU_MLS, 0,
                       3, 4, 5, 0, 32'h5, 0, 1, 0);
        send_and_check(m_word(4'd5, 4'd3, 4'd1, 4'd2, OPC_GEMM), FU_GEMM, 0,
                       5, 3, 1, 2, 0, 0, 1, 1);
        check_field("t1 behind mload", TAG_LOAD, issue_t1);
        retire(1, FU_GEMM, 0, 0, 1, 5);
        retire(1, FU_MLS, 0, 0, 0, 0);
        fork
            send_and_check(m_word(4'd3, 4'd5, 4'd5, 4'd5, OPC_GEMM), FU_GEMM, 0,
                           3, 5, 5, 5, 0, 0, 1, 1);
            begin
                hold_stall(3);
                retire(0, FU_NONE, 0, 0, 1, 3);
            end
        join
        retire(1, FU_GEMM, 0, 0, 1, 3);
    endtask

    task automatic spec_flush();
        test_name = "spec_flush";
        // backward bne x1, x2 whose low offset bits also fill the rd field
        send_and_check(b_word(13'h15a4, 5'd2, 5'd1, 3'b001), FU_BR, 4'b0001,
                       4, 1, 2, 0, 32'hfffff5a4, 0, 0, 0);
        send_and_check(r_word(7'd0, 5'd2, 5'd1, 3'b000, 5'd7), FU_ALU, 0, 7, 1, 2, 0, 0, 1, 0, 0);
        check_field("spec after branch", 1, issue_spec);
        // mispredict while a reader of x7 is on offer
        instr       = r_word(7'd0, 5'd0, 5'd7, 3'b000, 5'd13);
        instr_valid = 1'b1;
        branch_miss = 1'b1;
        @(negedge CLK);
        check_field("instr_ready during miss", 1, instr_ready);
        @(posedge CLK);
        #10;
        instr_valid = 1'b0;
        branch_miss = 1'b0;
        for (int i = 0; i < S_REGS; i++) begin
            if (s_spec[i]) begin
                s_tags[i] = TAG_NONE;
                s_spec[i] = 1'b0;
            end
        end
        for (int i = 0; i < M_REGS; i++) begin
            if (m_spec[i]) begin
                m_tags[i] = TAG_NONE;
                m_spec[i] = 1'b0;
            end
        end
        spec_m = 1'b0;
        check_field("issue_valid after miss", 0, issue_valid);
        retire(1, FU_ALU, 0, 0, 0, 0);
        retire(1, FU_BR, 0, 0, 0, 0);
        send_and_check(r_word(7'd0, 5'd0, 5'd7, 3'b000, 5'd14), FU_ALU, 0,
                       14, 7, 0, 0, 0, 1, 0, 0);
        check_field("t1 after flush", TAG_NONE, issue_t1);
        retire(1, FU_ALU, 1, 14, 0, 0);
    endtask

    task automatic random_stream();
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  alu_rd;
        logic [2:0]  f3;
        logic        kind;
        test_name = "random_stream";
        alu_rd    = '0;
        for (int n = 0; n < 24; n++) begin
            // outstanding units come back at random points
            if (busy[FU_ALU] && ($random(seed) & 1)) begin
                retire(1, FU_ALU, 1, alu_rd, 0, 0);
            end
            if (busy[FU_SLS] && ($random(seed) & 1)) begin
                retire(1, FU_SLS, 0, 0, 0, 0);
            end
            kind = $random(seed);
            imm  = $random(seed);
            rd   = $random(seed);
            rs1  = $random(seed);
            rs2  = $random(seed);
            f3   = $random(seed);
            if (!kind) begin
                if (busy[FU_ALU]) begin
                    retire(1, FU_ALU, 1, alu_rd, 0, 0);
                end
                send_and_check(i_word(imm, rs1, f3, rd, OPC_OPIMM), FU_ALU,
                               (f3 == 3'b101) ? {imm[10], f3} : {1'b0, f3},
                               rd, rs1, imm[4:0], 0, {{20{imm[11]}}, imm}, 1, 0, 0);
                alu_rd = rd;
            end else begin
                if (busy[FU_SLS]) begin
                    retire(1, FU_SLS, 0, 0, 0, 0);
                end
                send_and_check(s_word(imm, rs2, rs1, f3), FU_SLS, 0, imm[4:0], rs1, rs2, 0,
                               {{20{imm[11]}}, imm}, 0, 0, 0);
            end
        end
        if (busy[FU_SLS]) begin
            retire(1, FU_SLS, 0, 0, 0, 0);
        end
        if (busy[FU_ALU]) begin
            retire(1, FU_ALU, 1, alu_rd, 0, 0);
        end
    endtask

    initial begin
        CLK             = 1'b0;
        nRST            = 1'b0;
        instr_valid     = 1'b0;
        instr           = '0;
        fu_done_valid   = 1'b0;
        fu_done_id      = FU_NONE;
        s_wb_en         = 1'b0;
        s_wb_reg        = '0;
        m_wb_en         = 1'b0;
        m_wb_reg        = '0;
        branch_resolved = 1'b0;
        branch_miss     = 1'b0;
        errors          = 0;
        checks          = 0;
        cycles          = 0;
        seed            = 32'h4773;
        test_name       = "reset";
        busy            = '0;
        spec_m          = 1'b0;
        for (int i = 0; i < S_REGS; i++) begin
            s_tags[i] = TAG_NONE;
            s_spec[i] = 1'b0;
        end
        for (int i = 0; i < M_REGS; i++) begin
            m_tags[i] = TAG_NONE;
            m_spec[i] = 1'b0;
        end
        repeat (16) @(posedge CLK);
        #10;
        nRST = 1'b1;
        reset_state();
        raw_tags();
        stall_release();
        matrix_path();
        spec_flush();
        random_stream();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- sim.f
dispatch_pkg.sv
control_unit.sv
reg_status_table.sv
fu_status.sv
dispatch.sv
dispatch_top.sv
tb_dispatch.sv

//--- Makefile
TOOL     = verilator
TOP      = tb_dispatch
FILELIST = sim.f
FLAGS    = --binary --timing -Wno-fatal
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
